/* rtl/rgf_params.svh */
`ifndef RGF_PARAMS_SVH
`define RGF_PARAMS_SVH

// APB port widths.
`define RGF_DATA_W         32
`define RGF_ADDR_W         8

// Register byte offsets.
`define RGF_CTRL_OFS       8'h00
`define RGF_LIMIT_OFS      8'h04
`define RGF_STATUS_OFS     8'h08
`define RGF_MASK_OFS       8'h0C
`define RGF_TRIG_OFS       8'h10
`define RGF_HWVAL_OFS      8'h14

`define RGF_DEFAULT_RDATA  32'hDEAD_BEAF  // Returned on unmapped reads.
`define RGF_LIMIT_RESET    16'h00FF
`define RGF_EVENT_N        4

`endif

/* rtl/rgf_pkg.sv */
`default_nettype none

`include "rgf_params.svh"

package rgf_pkg;

  // Control word, bits 6:0.
  typedef struct packed {
    logic       enable;
    logic [1:0] mode;
    logic [3:0] threshold;
  } ctrl_t;

  typedef logic [15:0] limit_t;

  typedef logic [`RGF_EVENT_N-1:0] event_t;  // One bit per event.

  typedef struct packed {
    logic ctrl;
    logic limit;
    logic status;
    logic mask;
    logic trig;
    logic hwval;
  } reg_sel_t;

  typedef enum logic [1:0] {APB_IDLE, APB_WAIT, APB_READY} apb_state_t;

endpackage

`default_nettype wire

/* rtl/apb_access_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_access_fsm
  import rgf_pkg::*;
(
  input  logic clk,
  input  logic i_arst_n,
  input  logic i_psel,
  input  logic i_penable,
  input  logic i_pwrite,
  output logic o_pready,
  output logic o_wr_stb,
  output logic o_rd_stb
);

  apb_state_t state_q;
  apb_state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE: begin
        if (i_psel && !i_penable) begin
          state_d = APB_WAIT;  // Setup phase seen.
        end
      end
      APB_WAIT: begin
        // First access cycle is the wait state.
        if (!i_psel) begin
          state_d = APB_IDLE;
        end else if (i_penable) begin
          state_d = APB_READY;
        end
      end
      default: begin
        state_d = APB_IDLE;  // Ready lasts one cycle.
      end
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q  <= APB_IDLE;
      o_pready <= 1'b0;
      o_wr_stb <= 1'b0;
      o_rd_stb <= 1'b0;
    end else begin
      state_q  <= state_d;
      o_pready <= (state_d == APB_READY);
      o_wr_stb <= (state_d == APB_READY) && i_pwrite;
      o_rd_stb <= (state_d == APB_READY) && !i_pwrite;
    end
  end

  // Master must still be in the access phase when ready rises.
  pready_in_access_a: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    o_pready |-> (i_psel && i_penable)
  );

endmodule

`default_nettype wire

/* rtl/rgf_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rgf_params.svh"

module rgf_decoder
  import rgf_pkg::*;
(
  input  logic [`RGF_ADDR_W-1:0] i_paddr,
  input  ctrl_t                  i_ctrl,
  input  limit_t                 i_limit,
  input  event_t                 i_status,
  input  event_t                 i_mask,
  input  limit_t                 i_hw_value,
  output reg_sel_t               o_sel,
  output logic [`RGF_DATA_W-1:0] o_prdata,
  output logic                   o_pslverr
);

  // Word compare, byte lanes ignored.
  function automatic logic word_hit(input logic [`RGF_ADDR_W-1:0] addr,
                                    input logic [`RGF_ADDR_W-1:0] ofs);
    return addr[`RGF_ADDR_W-1:2] == ofs[`RGF_ADDR_W-1:2];
  endfunction

  assign o_sel.ctrl   = word_hit(i_paddr, `RGF_CTRL_OFS);
  assign o_sel.limit  = word_hit(i_paddr, `RGF_LIMIT_OFS);
  assign o_sel.status = word_hit(i_paddr, `RGF_STATUS_OFS);
  assign o_sel.mask   = word_hit(i_paddr, `RGF_MASK_OFS);
  assign o_sel.trig   = word_hit(i_paddr, `RGF_TRIG_OFS);
  assign o_sel.hwval  = word_hit(i_paddr, `RGF_HWVAL_OFS);

  always_comb begin
    o_prdata  = '0;  // Trigger reads back zero.
    o_pslverr = (o_sel == '0);
    if (o_pslverr) begin
      o_prdata = `RGF_DEFAULT_RDATA;
    end else if (o_sel.ctrl) begin
      o_prdata[$bits(ctrl_t)-1:0] = i_ctrl;
    end else if (o_sel.limit) begin
      o_prdata[$bits(limit_t)-1:0] = i_limit;
    end else if (o_sel.status) begin
      o_prdata[$bits(event_t)-1:0] = i_status;
    end else if (o_sel.mask) begin
      o_prdata[$bits(event_t)-1:0] = i_mask;
    end else if (o_sel.hwval) begin
      o_prdata[$bits(limit_t)-1:0] = i_hw_value;
    end
  end

  always_comb begin
    sel_onehot_a: assert ($onehot0(o_sel));
  end

endmodule

`default_nettype wire

/* rtl/rw_field_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rgf_params.svh"

module rw_field_reg
  import rgf_pkg::*;
#(
  parameter type    T_FIELD     = event_t,
  parameter T_FIELD RESET_VALUE = '0
) (
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_wr,
  input  logic [`RGF_DATA_W-1:0] i_wdata,
  output T_FIELD                 o_value
);

  localparam int FIELD_W = $bits(T_FIELD);

  logic [FIELD_W-1:0] wr_field;

  assign wr_field = i_wdata[FIELD_W-1:0];  // Upper write bits dropped.

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_value <= RESET_VALUE;
    end else if (i_wr) begin
      o_value <= T_FIELD'(wr_field);
    end
  end

endmodule

`default_nettype wire

/* rtl/status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rgf_params.svh"

module status_regs
  import rgf_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_status_wr,
  input  logic                   i_trig_wr,
  input  logic [`RGF_DATA_W-1:0] i_wdata,
  input  event_t                 i_event,
  input  event_t                 i_mask,
  output event_t                 o_status,
  output event_t                 o_trigger,
  output logic                   o_irq
);

  event_t wr_bits;
  event_t clr_bits;
  event_t status_d;

  assign wr_bits  = i_wdata[`RGF_EVENT_N-1:0];
  assign clr_bits = i_status_wr ? wr_bits : '0;

  // Set wins over a clear on the same edge.
  assign status_d = (o_status & ~clr_bits) | i_event;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_status <= '0;
    end else begin
      o_status <= status_d;
    end
  end

  // One-cycle pulse after the ready cycle.
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_trigger <= '0;
    end else if (i_trig_wr) begin
      o_trigger <= wr_bits;
    end else begin
      o_trigger <= '0;
    end
  end

  assign o_irq = |(o_status & i_mask);

  // A pulse never lasts two cycles, so strobes from the sequencer stay single.
  trigger_single_a: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    (o_trigger != '0) |=> ((o_trigger & $past(o_trigger)) == '0)
  );

endmodule

`default_nettype wire

/* rtl/rgf_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rgf_params.svh"

module rgf_top
  import rgf_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_arst_n,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`RGF_ADDR_W-1:0] i_paddr,
  input  logic [`RGF_DATA_W-1:0] i_pwdata,
  output logic                   o_pready,
  output logic [`RGF_DATA_W-1:0] o_prdata,
  output logic                   o_pslverr,
  input  event_t                 i_event,
  input  limit_t                 i_hw_value,
  output ctrl_t                  o_ctrl,
  output limit_t                 o_limit,
  output event_t                 o_trigger,
  output logic                   o_irq
);

  logic     wr_stb;
  reg_sel_t sel;
  event_t   mask;
  event_t   status;

  apb_access_fsm fsm_i (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .o_pready  (o_pready),
    .o_wr_stb  (wr_stb),
    .o_rd_stb  ()
  );

  rgf_decoder decoder_i (
    .i_paddr    (i_paddr),
    .i_ctrl     (o_ctrl),
    .i_limit    (o_limit),
    .i_status   (status),
    .i_mask     (mask),
    .i_hw_value (i_hw_value),
    .o_sel      (sel),
    .o_prdata   (o_prdata),
    .o_pslverr  (o_pslverr)
  );

  rw_field_reg #(
    .T_FIELD     (ctrl_t),
    .RESET_VALUE ('0)
  ) ctrl_reg_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_wr     (wr_stb && sel.ctrl),
    .i_wdata  (i_pwdata),
    .o_value  (o_ctrl)
  );

  rw_field_reg #(
    .T_FIELD     (limit_t),
    .RESET_VALUE (`RGF_LIMIT_RESET)
  ) limit_reg_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_wr     (wr_stb && sel.limit),
    .i_wdata  (i_pwdata),
    .o_value  (o_limit)
  );

  rw_field_reg #(
    .T_FIELD     (event_t),
    .RESET_VALUE ('0)
  ) mask_reg_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_wr     (wr_stb && sel.mask),
    .i_wdata  (i_pwdata),
    .o_value  (mask)
  );

  status_regs status_regs_i (
    .clk         (clk),
    .i_arst_n    (i_arst_n),
    .i_status_wr (wr_stb && sel.status),
    .i_trig_wr   (wr_stb && sel.trig),
    .i_wdata     (i_pwdata),
    .i_event     (i_event),
    .i_mask      (mask),
    .o_status    (status),
    .o_trigger   (o_trigger),
    .o_irq       (o_irq)
  );

endmodule

`default_nettype wire

/* verification/rgf_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rgf_params.svh"

module rgf_tb
  import rgf_pkg::*;
;

  localparam int MAX_CYCLES = 400;

  logic                   clk;
  logic                   i_arst_n;
  logic                   i_psel;
  logic                   i_penable;
  logic                   i_pwrite;
  logic [`RGF_ADDR_W-1:0] i_paddr;
  logic [`RGF_DATA_W-1:0] i_pwdata;
  logic                   o_pready;
  logic [`RGF_DATA_W-1:0] o_prdata;
  logic                   o_pslverr;
  event_t                 i_event;
  limit_t                 i_hw_value;
  ctrl_t                  o_ctrl;
  limit_t                 o_limit;
  event_t                 o_trigger;
  logic                   o_irq;

  // Expected state of the register file.
  logic [6:0]             m_ctrl;
  limit_t                 m_limit;
  event_t                 m_mask;
  event_t                 m_status;
  event_t                 exp_trig;
  logic [`RGF_DATA_W-1:0] exp_rdata;
  logic                   exp_err;
  logic                   exp_ready;
  logic [`RGF_DATA_W-1:0] rnd;
  integer                 seed;
  int                     errors;
  int                     xfers;
  int                     cycles;

  rgf_top rgf_top_i (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  // Status bits: set by events, cleared by writes of one, set wins.
  always @(posedge clk) begin
    if (!i_arst_n) begin
      m_status <= '0;
      exp_trig <= '0;
    end else begin
      m_status <= (m_status & ~((o_pready && i_pwrite && i_paddr == `RGF_STATUS_OFS) ?
                                i_pwdata[`RGF_EVENT_N-1:0] : '0)) | i_event;
      exp_trig <= (o_pready && i_pwrite && i_paddr == `RGF_TRIG_OFS) ?
                  i_pwdata[`RGF_EVENT_N-1:0] : '0;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $finish;
    end
  end

  ready_a: assert property (@(posedge clk) disable iff (!i_arst_n) o_pready == exp_ready)
    else begin
      errors = errors + 1;
      $display("ERR o_pready got %h expected %h", $sampled(o_pready), exp_ready);
    end

  rdata_a: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_pready && !i_pwrite) |-> (o_prdata == exp_rdata))
    else begin
      errors = errors + 1;
      $display("ERR o_prdata got %h expected %h", $sampled(o_prdata), exp_rdata);
    end

  pslverr_a: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_pready |-> (o_pslverr == exp_err))
    else begin
      errors = errors + 1;
      $display("ERR o_pslverr got %h expected %h", $sampled(o_pslverr), exp_err);
    end

  ctrl_a: assert property (@(posedge clk) disable iff (!i_arst_n) o_ctrl == m_ctrl)
    else begin
      errors = errors + 1;
      $display("ERR o_ctrl got %h expected %h", $sampled(o_ctrl), m_ctrl);
    end

  limit_a: assert property (@(posedge clk) disable iff (!i_arst_n) o_limit == m_limit)
    else begin
      errors = errors + 1;
      $display("ERR o_limit got %h expected %h", $sampled(o_limit), m_limit);
    end

  trigger_a: assert property (@(posedge clk) disable iff (!i_arst_n) o_trigger == exp_trig)
    else begin
      errors = errors + 1;
      $display("ERR o_trigger got %h expected %h", $sampled(o_trigger),
               $sampled(exp_trig));
    end

  irq_a: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_irq == |(m_status & m_mask))
    else begin
      errors = errors + 1;
      $display("ERR o_irq got %h expected %h", $sampled(o_irq),
               |($sampled(m_status) & m_mask));
    end

  function automatic logic is_mapped(input logic [`RGF_ADDR_W-1:0] addr);
    return addr == `RGF_CTRL_OFS || addr == `RGF_LIMIT_OFS || addr == `RGF_STATUS_OFS ||
           addr == `RGF_MASK_OFS || addr == `RGF_TRIG_OFS || addr == `RGF_HWVAL_OFS;
  endfunction

  function automatic logic [`RGF_DATA_W-1:0] expected_word(input logic [`RGF_ADDR_W-1:0] addr);
    case (addr)
      `RGF_CTRL_OFS:   return {25'd0, m_ctrl};
      `RGF_LIMIT_OFS:  return {16'd0, m_limit};
      `RGF_STATUS_OFS: return {28'd0, m_status};
      `RGF_MASK_OFS:   return {28'd0, m_mask};
      `RGF_TRIG_OFS:   return '0;
      `RGF_HWVAL_OFS:  return {16'd0, i_hw_value};
      default:         return `RGF_DEFAULT_RDATA;
    endcase
  endfunction

  // Setup, wait state, ready; ev is driven onto i_event at the write edge.
  task automatic apb_transfer(input logic wr, input logic [`RGF_ADDR_W-1:0] addr,
                              input logic [`RGF_DATA_W-1:0] data, input event_t ev);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = data;
    @(negedge clk);
    i_penable = 1'b1;
    @(negedge clk);
    exp_ready = 1'b1;  // Second access cycle.
    i_event   = ev;
    @(negedge clk);
    exp_ready = 1'b0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_event   = '0;
    xfers     = xfers + 1;
  endtask

  task automatic apb_write(input logic [`RGF_ADDR_W-1:0] addr,
                           input logic [`RGF_DATA_W-1:0] data, input event_t ev);
    exp_err = !is_mapped(addr);
    apb_transfer(1'b1, addr, data, ev);
    case (addr)
      `RGF_CTRL_OFS:  m_ctrl  = data[6:0];
      `RGF_LIMIT_OFS: m_limit = data[15:0];
      `RGF_MASK_OFS:  m_mask  = data[`RGF_EVENT_N-1:0];
      default: ;
    endcase
  endtask

  task automatic apb_read(input logic [`RGF_ADDR_W-1:0] addr);
    exp_rdata = expected_word(addr);
    exp_err   = !is_mapped(addr);
    apb_transfer(1'b0, addr, '0, '0);
  endtask

  task automatic pulse_event(input event_t ev);
    @(negedge clk);
    i_event = ev;
    @(negedge clk);
    i_event = '0;
  endtask

  task automatic read_all();
    apb_read(`RGF_CTRL_OFS);
    apb_read(`RGF_LIMIT_OFS);
    apb_read(`RGF_STATUS_OFS);
    apb_read(`RGF_MASK_OFS);
  endtask

  initial begin
    seed       = 68;
    errors     = 0;
    xfers      = 0;
    cycles     = 0;
    i_arst_n   = 1'b0;
    i_psel     = 1'b0;
    i_penable  = 1'b0;
    i_pwrite   = 1'b0;
    i_paddr    = '0;
    i_pwdata   = '0;
    i_event    = '0;
    i_hw_value = '0;
    m_ctrl     = '0;
    m_limit    = `RGF_LIMIT_RESET;
    m_mask     = '0;
    exp_rdata  = '0;
    exp_err    = 1'b0;
    exp_ready  = 1'b0;
    rnd        = '0;
    repeat (10) @(negedge clk);
    i_arst_n = 1'b1;

    read_all();  // Reset values.

    repeat (3) begin
      rnd = $random(seed);
      apb_write(`RGF_CTRL_OFS, rnd, '0);
      rnd = $random(seed);
      apb_write(`RGF_LIMIT_OFS, rnd, '0);
      rnd = $random(seed);
      apb_write(`RGF_MASK_OFS, rnd, '0);
      read_all();
    end

    rnd = $random(seed);
    i_hw_value = rnd[15:0];
    apb_read(`RGF_HWVAL_OFS);

    apb_write(`RGF_MASK_OFS, 32'h5, '0);
    pulse_event(4'b0011);
    apb_read(`RGF_STATUS_OFS);
    rnd = $random(seed);
    pulse_event(rnd[3:0]);
    apb_read(`RGF_STATUS_OFS);
    apb_write(`RGF_STATUS_OFS, 32'h1, '0);
    apb_read(`RGF_STATUS_OFS);
    apb_write(`RGF_STATUS_OFS, 32'hF, 4'b0010);  // Event on the clear edge.
    apb_read(`RGF_STATUS_OFS);
    apb_write(`RGF_STATUS_OFS, 32'hF, '0);
    apb_read(`RGF_STATUS_OFS);

    rnd = $random(seed);
    apb_write(`RGF_TRIG_OFS, rnd | 32'h1, '0);
    apb_write(`RGF_TRIG_OFS, 32'hA, '0);
    apb_read(`RGF_TRIG_OFS);

    pulse_event(4'b1100);
    apb_read(8'h40);
    rnd = $random(seed);
    apb_write({1'b1, rnd[6:2], 2'b00}, $random(seed), '0);  // Always above the map.
    read_all();

    @(negedge clk);
    $display("Summary: %0d transfers, %0d errors", xfers, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/rgf_pkg.sv
rtl/apb_access_fsm.sv
rtl/rgf_decoder.sv
rtl/rw_field_reg.sv
rtl/status_regs.sv
rtl/rgf_top.sv
verification/rgf_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the register block testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module rgf_tb \
  -f files.f --Mdir obj_dir -o rgf_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/rgf_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
